//--- hdl/snake_config.svh
/*
 * screen, grid and colour constants for the snake game
 * coordinates are 11-bit pixel positions and all squares are grid aligned
 */
`ifndef SNAKE_CONFIG_SVH
`define SNAKE_CONFIG_SVH

`define SNAKE_H_DISP    11'd1280    // visible width
`define SNAKE_V_DISP    11'd720     // visible height
`define SNAKE_SIDE_W    11'd40      // border thickness
`define SNAKE_BLOCK_W   11'd20      // snake block and food edge

`define SNAKE_MAX_LEN   10          // number of segment cells
`define SNAKE_INIT_LEN  3

`define SNAKE_INIT_X    11'd640     // head start position
`define SNAKE_INIT_Y    11'd320
`define SNAKE_FOOD_X0   11'd360     // food start position
`define SNAKE_FOOD_Y0   11'd400

`define COLOR_BORDER    24'h0000ff
`define COLOR_SNAKE     24'h00ff00
`define COLOR_FOOD      24'hdc143c
`define COLOR_BACK      24'hffffff

`endif

//--- hdl/snake_pkg.sv
/*
 * shared types for the snake game
 * pos_t packs x above y, 11 bits each
 */
package snake_pkg;

    typedef logic [10:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    // movement direction of the head
    typedef enum logic [1:0] {
        DIR_UP,
        DIR_DOWN,
        DIR_LEFT,
        DIR_RIGHT
    } dir_t;

    typedef enum logic {
        MODE_MENU,
        MODE_PLAY
    } game_mode_t;

    // per-cell result for the current pixel and the next head
    typedef struct packed {
        logic pixel_hit;
        logic head_collide;
    } seg_report_t;

endpackage

//--- hdl/snake_steer.sv
/*
 * direction register, keys are levels: [0] up, [1] down, [2] left, [3] right
 * keys are sampled every clock, so two turns inside one step can still reverse
 */
`timescale 1ns/1ps

module snake_steer (
    input  logic                   pixel_clk,
    input  logic                   sys_rst_n,
    input  logic [3:0]             keys,
    input  snake_pkg::game_mode_t  mode,
    input  logic                   dead,
    output snake_pkg::dir_t        dir,
    output logic                   moving
);
    import snake_pkg::*;

    always_ff @(posedge pixel_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            dir    <= DIR_RIGHT;
            moving <= 1'b0;
        end
        else if (mode != MODE_PLAY)
        begin
            dir    <= DIR_RIGHT;    // back to start heading
            moving <= 1'b0;
        end
        else if (!dead)
        begin
            if (keys[0])
            begin
                if (dir != DIR_DOWN)
                    dir <= DIR_UP;
                moving <= 1'b1;
            end
            else if (keys[1])
            begin
                if (dir != DIR_UP)
                    dir <= DIR_DOWN;
                moving <= 1'b1;
            end
            else if (keys[2])
            begin
                // first left press would run into the body, keep going right
                if (!moving)
                    dir <= DIR_RIGHT;
                else if (dir != DIR_RIGHT)
                    dir <= DIR_LEFT;
                moving <= 1'b1;
            end
            else if (keys[3])
            begin
                if (dir != DIR_LEFT)
                    dir <= DIR_RIGHT;
                moving <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/snake_step_timer.sv
/*
 * speed 1..3 and step tick, one pulse every step_cycles/speed clocks
 * step_cycles must be 3 or more, a new speed takes effect at the next wrap
 */
`timescale 1ns/1ps

module snake_step_timer #(
    parameter int unsigned step_cycles = 7425000
) (
    input  logic       pixel_clk,
    input  logic       sys_rst_n,
    input  logic       speed_step,
    output logic [1:0] speed,
    output logic       step_tick
);
    localparam int cnt_w = $clog2(step_cycles);
    localparam logic [cnt_w-1:0] last_s1 = cnt_w'(step_cycles - 1);
    localparam logic [cnt_w-1:0] last_s2 = cnt_w'(step_cycles / 2 - 1);
    localparam logic [cnt_w-1:0] last_s3 = cnt_w'(step_cycles / 3 - 1);

    logic [1:0]       speed_nxt;
    logic [cnt_w-1:0] cnt;
    logic [cnt_w-1:0] cnt_last;    // terminal count of the running interval

    always_comb
    begin
        speed_nxt = speed;
        if (speed_step)
            speed_nxt = (speed == 2'd3) ? 2'd1 : speed + 2'd1;
    end

    always_ff @(posedge pixel_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            speed    <= 2'd1;
            cnt      <= '0;
            cnt_last <= last_s1;
        end
        else
        begin
            speed <= speed_nxt;
            if (step_tick)
            begin
                cnt <= '0;
                case (speed_nxt)    // limit for the interval that starts now
                    2'd2:    cnt_last <= last_s2;
                    2'd3:    cnt_last <= last_s3;
                    default: cnt_last <= last_s1;
                endcase
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

    assign step_tick = (cnt == cnt_last);

endmodule

//--- hdl/snake_head.sv
/*
 * game control: next head, wall and eat checks, length, food, dead and score
 * the head itself is segment 0, this block only computes where it goes next
 */
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_head (
    input  logic                   pixel_clk,
    input  logic                   sys_rst_n,
    input  snake_pkg::game_mode_t  mode,
    input  snake_pkg::dir_t        dir,
    input  logic                   moving,
    input  logic                   step_tick,
    input  logic [1:0]             speed,
    input  logic                   self_collide,
    input  snake_pkg::pos_t        seg0_pos,
    input  snake_pkg::pos_t        seg1_pos,
    output logic                   step,
    output logic                   clear,
    output snake_pkg::pos_t        next_head,
    output logic [3:0]             length,
    output snake_pkg::pos_t        food_pos,
    output logic                   dead,
    output logic [6:0]             score
);
    import snake_pkg::*;

    localparam int grid_cols = (`SNAKE_H_DISP - 2 * `SNAKE_SIDE_W) / `SNAKE_BLOCK_W;
    localparam int grid_rows = (`SNAKE_V_DISP - 2 * `SNAKE_SIDE_W) / `SNAKE_BLOCK_W;

    coord_t      seed_x;
    coord_t      seed_y;
    logic        wall_hit;
    logic        eat;
    logic [15:0] sum_x;
    logic [15:0] sum_y;
    pos_t        food_new;

    assign clear = (mode == MODE_MENU);
    assign step  = step_tick && (mode == MODE_PLAY) && moving && !dead;

    always_comb
    begin
        next_head = seg0_pos;
        case (dir)
            DIR_UP:    next_head.y = seg0_pos.y - `SNAKE_BLOCK_W;
            DIR_DOWN:  next_head.y = seg0_pos.y + `SNAKE_BLOCK_W;
            DIR_LEFT:  next_head.x = seg0_pos.x - `SNAKE_BLOCK_W;
            default:   next_head.x = seg0_pos.x + `SNAKE_BLOCK_W;
        endcase
    end

    // play field is the rectangle inside the border
    assign wall_hit = (next_head.x < `SNAKE_SIDE_W) ||
                      (next_head.x >= `SNAKE_H_DISP - `SNAKE_SIDE_W) ||
                      (next_head.y < `SNAKE_SIDE_W) ||
                      (next_head.y >= `SNAKE_V_DISP - `SNAKE_SIDE_W);

    assign eat = (next_head.x >= food_pos.x) && (next_head.x < food_pos.x + `SNAKE_BLOCK_W) &&
                 (next_head.y >= food_pos.y) && (next_head.y < food_pos.y + `SNAKE_BLOCK_W);

    // new food square, mixed from head, body and the seed generators
    always_comb
    begin
        sum_x = 16'd13 * next_head.x + 16'd7 * seg0_pos.x + 16'd2 * seg1_pos.x
              + 16'(seed_x) + 16'd234;
        sum_y = 16'd13 * next_head.y + 16'd7 * seg0_pos.y + 16'd2 * seg1_pos.y
              + 16'(seed_y) + 16'd123;
        food_new.x = coord_t'(`SNAKE_SIDE_W + `SNAKE_BLOCK_W * (sum_x % 16'(grid_cols)));
        food_new.y = coord_t'(`SNAKE_SIDE_W + `SNAKE_BLOCK_W * (sum_y % 16'(grid_rows)));
    end

    always_ff @(posedge pixel_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            seed_x <= 11'd135;
            seed_y <= 11'd246;
        end
        else
        begin
            seed_x <= (seed_x + 11'd1) ^ {3'b101, seed_x[10:3]};   // free running
            seed_y <= (seed_y + 11'd1) ^ {3'b010, seed_y[10:3]};
        end
    end

    always_ff @(posedge pixel_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            dead     <= 1'b0;
            length   <= 4'(`SNAKE_INIT_LEN);
            food_pos <= '{x: `SNAKE_FOOD_X0, y: `SNAKE_FOOD_Y0};
        end
        else if (clear)
        begin
            dead     <= 1'b0;               // menu restores the start state
            length   <= 4'(`SNAKE_INIT_LEN);
            food_pos <= '{x: `SNAKE_FOOD_X0, y: `SNAKE_FOOD_Y0};
        end
        else if (step)
        begin
            if (wall_hit || self_collide)
                dead <= 1'b1;               // freezes everything until menu
            if (eat)
            begin
                if (length < 4'(`SNAKE_MAX_LEN))
                    length <= length + 4'd1;
                food_pos <= food_new;
            end
        end
    end

    always_ff @(posedge pixel_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            score <= '0;
        else
            score <= 7'((length - 4'(`SNAKE_INIT_LEN)) * speed * 7'd5);   // max 105
    end

endmodule

//--- hdl/snake_segment.sv
/*
 * one body cell, index idx counted from the head
 * cells past the current length keep shifting but report nothing
 */
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_segment #(
    parameter int idx = 0
) (
    input  logic                   pixel_clk,
    input  logic                   sys_rst_n,
    input  logic                   step,
    input  logic                   clear,
    input  snake_pkg::pos_t        shift_in,
    input  snake_pkg::pos_t        next_head,
    input  logic [3:0]             length,
    input  snake_pkg::pos_t        pixel_pos,
    output snake_pkg::pos_t        pos,
    output snake_pkg::seg_report_t report
);
    import snake_pkg::*;

    localparam pos_t init_pos = '{x: coord_t'(`SNAKE_INIT_X - idx * `SNAKE_BLOCK_W),
                                  y: `SNAKE_INIT_Y};

    logic active;
    logic not_tail;    // the tail leaves its square on this step

    assign active   = (length > 4'(idx));
    assign not_tail = (4'(idx + 2) <= length);

    always_ff @(posedge pixel_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            pos <= init_pos;
        else if (clear)
            pos <= init_pos;    // start layout, heading right
        else if (step)
            pos <= shift_in;
    end

    assign report.pixel_hit = active &&
        (pixel_pos.x >= pos.x) && (pixel_pos.x < pos.x + `SNAKE_BLOCK_W) &&
        (pixel_pos.y >= pos.y) && (pixel_pos.y < pos.y + `SNAKE_BLOCK_W);
    assign report.head_collide = not_tail && (pos == next_head);

endmodule

//--- hdl/snake_pixel_mix.sv
/*
 * pixel colour, registered one clock after pixel_pos
 * priority in play is border, snake, food, then background
 */
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_pixel_mix (
    input  logic                        pixel_clk,
    input  logic                        sys_rst_n,
    input  snake_pkg::game_mode_t       mode,
    input  snake_pkg::pos_t             pixel_pos,
    input  logic [`SNAKE_MAX_LEN-1:0]   snake_hit,
    input  snake_pkg::pos_t             food_pos,
    output logic [23:0]                 pixel_data
);
    import snake_pkg::*;

    logic in_border;
    logic in_food;

    assign in_border = (pixel_pos.x < `SNAKE_SIDE_W) ||
                       (pixel_pos.x >= `SNAKE_H_DISP - `SNAKE_SIDE_W) ||
                       (pixel_pos.y < `SNAKE_SIDE_W) ||
                       (pixel_pos.y >= `SNAKE_V_DISP - `SNAKE_SIDE_W);

    assign in_food = (pixel_pos.x >= food_pos.x) &&
                     (pixel_pos.x < food_pos.x + `SNAKE_BLOCK_W) &&
                     (pixel_pos.y >= food_pos.y) &&
                     (pixel_pos.y < food_pos.y + `SNAKE_BLOCK_W);

    always_ff @(posedge pixel_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            pixel_data <= '0;
        else if (mode == MODE_MENU)
            pixel_data <= `COLOR_BACK;      // plain menu screen
        else if (in_border)
            pixel_data <= `COLOR_BORDER;
        else if (|snake_hit)
            pixel_data <= `COLOR_SNAKE;
        else if (in_food)
            pixel_data <= `COLOR_FOOD;
        else
            pixel_data <= `COLOR_BACK;
    end

endmodule

//--- hdl/snake_video_top.sv
/*
 * snake game pixel generator, colour appears one clock after pixel_pos
 * keys are levels [0] up, [1] down, [2] left, [3] right, speed_step is a strobe
 */
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_video_top #(
    parameter int unsigned step_cycles = 7425000
) (
    input  logic                   pixel_clk,
    input  logic                   sys_rst_n,
    input  snake_pkg::pos_t        pixel_pos,
    input  logic [3:0]             keys,
    input  logic                   speed_step,
    input  snake_pkg::game_mode_t  mode,
    output logic [23:0]            pixel_data,
    output logic [6:0]             score,
    output logic                   dead
);
    import snake_pkg::*;

    logic                      step_tick;
    logic [1:0]                speed;
    dir_t                      dir;
    logic                      moving;
    logic                      step;
    logic                      clear;
    pos_t                      next_head;
    logic [3:0]                length;
    pos_t                      food_pos;
    logic                      self_collide;
    pos_t                      seg_pos [`SNAKE_MAX_LEN];
    seg_report_t               seg_report [`SNAKE_MAX_LEN];
    logic [`SNAKE_MAX_LEN-1:0] hit_bits;
    logic [`SNAKE_MAX_LEN-1:0] collide_bits;

    snake_step_timer #(.step_cycles(step_cycles)) step_timer_i (
        .pixel_clk, .sys_rst_n, .speed_step, .speed, .step_tick
    );

    snake_steer steer_i (
        .pixel_clk, .sys_rst_n, .keys, .mode, .dead, .dir, .moving
    );

    snake_head head_i (
        .pixel_clk, .sys_rst_n, .mode, .dir, .moving, .step_tick, .speed, .self_collide,
        .seg0_pos(seg_pos[0]), .seg1_pos(seg_pos[1]),
        .step, .clear, .next_head, .length, .food_pos, .dead, .score
    );

    // shift chain, cell 0 is the head and takes next_head
    for (genvar i = 0; i < `SNAKE_MAX_LEN; i++)
    begin : g_seg
        pos_t shift_src;
        if (i == 0)
        begin : g_first
            assign shift_src = next_head;
        end
        else
        begin : g_rest
            assign shift_src = seg_pos[i-1];
        end

        snake_segment #(.idx(i)) seg_i (
            .pixel_clk, .sys_rst_n, .step, .clear, .shift_in(shift_src), .next_head,
            .length, .pixel_pos, .pos(seg_pos[i]), .report(seg_report[i])
        );

        assign hit_bits[i]     = seg_report[i].pixel_hit;
        assign collide_bits[i] = seg_report[i].head_collide;
    end

    assign self_collide = |collide_bits;

    snake_pixel_mix pixel_mix_i (
        .pixel_clk, .sys_rst_n, .mode, .pixel_pos, .snake_hit(hit_bits), .food_pos,
        .pixel_data
    );

endmodule

//--- dv/snake_checker.sv
/*
 * game rule assertions, bound into every snake_video_top instance
 * checked only while reset is released
 */
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_checker (
    input logic                  pixel_clk,
    input logic                  sys_rst_n,
    input snake_pkg::game_mode_t mode,
    input logic                  dead,
    input logic [3:0]            length,
    input snake_pkg::pos_t       head_pos
);
    import snake_pkg::*;

    int fail_cnt = 0;

    // only the menu brings a dead snake back
    dead_holds: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        (dead && mode == MODE_PLAY) |=> dead)
        else
        begin
            fail_cnt++;
            $error("dead fell while the mode was play");
        end

    length_range: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        (length >= 4'(`SNAKE_INIT_LEN)) && (length <= 4'(`SNAKE_MAX_LEN)))
        else
        begin
            fail_cnt++;
            $error("length left the range 3 to 10");
        end

    // no step reaches the cells once the snake is dead
    head_frozen: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        (dead && mode == MODE_PLAY) |=> $stable(head_pos))
        else
        begin
            fail_cnt++;
            $error("the head moved while dead");
        end

endmodule

bind snake_video_top snake_checker chk_i (
    .pixel_clk, .sys_rst_n, .mode, .dead, .length, .head_pos(seg_pos[0])
);

//--- dv/snake_tb.sv
/*
 * snake game testbench, random keys and speed strobes from a fixed seed
 * a cycle model of the game is checked against the DUT on every falling edge
 */
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_tb;
    import snake_pkg::*;

    localparam int step_cycles = 60;
    localparam int side_w      = int'(`SNAKE_SIDE_W);
    localparam int blk         = int'(`SNAKE_BLOCK_W);
    localparam int h_disp      = int'(`SNAKE_H_DISP);
    localparam int v_disp      = int'(`SNAKE_V_DISP);
    localparam int max_len     = `SNAKE_MAX_LEN;
    localparam int init_len    = `SNAKE_INIT_LEN;

    logic        pixel_clk;
    logic        sys_rst_n;
    pos_t        pixel_pos;
    logic [3:0]  keys;
    logic        speed_step;
    game_mode_t  mode;
    logic [23:0] pixel_data;
    logic [6:0]  score;
    logic        dead;

    int          seed;
    int          errors;
    int          checks;
    logic        force_up;

    // reference model state
    int          seed_x_m;
    int          seed_y_m;
    int          speed_m;
    int          cnt_m;
    int          last_m;
    logic        tick_m;
    dir_t        dir_m;
    logic        moving_m;
    logic        step_m;
    logic        dead_m;
    int          len_m;
    int          food_x_m;
    int          food_y_m;
    int          eats_m;
    int          seg_x_m [max_len];
    int          seg_y_m [max_len];
    logic [23:0] pix_m;
    logic [6:0]  score_m;

    snake_video_top #(.step_cycles(step_cycles)) snake_video_top_i (
        .pixel_clk, .sys_rst_n, .pixel_pos, .keys, .speed_step, .mode,
        .pixel_data, .score, .dead
    );

    initial
        pixel_clk = 1'b0;
    always #2 pixel_clk = ~pixel_clk;

    function automatic int rand_below(int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic bit in_square(int px, int py, int sx, int sy);
        return (px >= sx) && (px < sx + blk) && (py >= sy) && (py < sy + blk);
    endfunction

    function automatic bit is_reverse(dir_t a, dir_t b);
        return (a == DIR_UP && b == DIR_DOWN) || (a == DIR_DOWN && b == DIR_UP) ||
               (a == DIR_LEFT && b == DIR_RIGHT) || (a == DIR_RIGHT && b == DIR_LEFT);
    endfunction

    // colour the model expects for a pixel, given its current state
    function automatic logic [23:0] expected_pixel(int px, int py);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < max_len; i++)
            if (i < len_m && in_square(px, py, seg_x_m[i], seg_y_m[i]))
                hit = 1'b1;
        if (mode == MODE_MENU)
            return `COLOR_BACK;
        if (px < side_w || px >= h_disp - side_w || py < side_w || py >= v_disp - side_w)
            return `COLOR_BORDER;
        if (hit)
            return `COLOR_SNAKE;
        if (in_square(px, py, food_x_m, food_y_m))
            return `COLOR_FOOD;
        return `COLOR_BACK;
    endfunction

    task automatic reset_model();
        seed_x_m = 135;
        seed_y_m = 246;
        speed_m  = 1;
        cnt_m    = 0;
        last_m   = step_cycles - 1;
        tick_m   = 1'b0;
        dir_m    = DIR_RIGHT;
        moving_m = 1'b0;
        step_m   = 1'b0;
        dead_m   = 1'b0;
        len_m    = init_len;
        food_x_m = int'(`SNAKE_FOOD_X0);
        food_y_m = int'(`SNAKE_FOOD_Y0);
        pix_m    = '0;
        score_m  = '0;
        for (int i = 0; i < max_len; i++)
        begin
            seg_x_m[i] = int'(`SNAKE_INIT_X) - blk * i;
            seg_y_m[i] = int'(`SNAKE_INIT_Y);
        end
    endtask

    always @(posedge pixel_clk or negedge sys_rst_n)
    begin
        int   nx;
        int   ny;
        int   spd;
        logic wall;
        logic eat;
        logic coll;
        dir_t req;
        if (!sys_rst_n)
            reset_model();
        else
        begin
            // everything below reads the state from before this edge
            pix_m   = expected_pixel(int'(pixel_pos.x), int'(pixel_pos.y));
            score_m = 7'((len_m - init_len) * speed_m * 5);
            spd = speed_m;
            if (speed_step)
                spd = (speed_m == 3) ? 1 : speed_m + 1;
            step_m = tick_m && (mode == MODE_PLAY) && moving_m && !dead_m;
            nx = seg_x_m[0];
            ny = seg_y_m[0];
            case (dir_m)
                DIR_UP:   ny = (ny - blk) & 32'h7ff;
                DIR_DOWN: ny = ny + blk;
                DIR_LEFT: nx = (nx - blk) & 32'h7ff;
                default:  nx = nx + blk;
            endcase
            wall = (nx < side_w) || (nx >= h_disp - side_w) ||
                   (ny < side_w) || (ny >= v_disp - side_w);
            eat  = in_square(nx, ny, food_x_m, food_y_m);
            coll = 1'b0;
            for (int i = 0; i < max_len; i++)
                if (i + 2 <= len_m && seg_x_m[i] == nx && seg_y_m[i] == ny)
                    coll = 1'b1;

            if (tick_m)
            begin
                cnt_m  = 0;
                last_m = step_cycles / spd - 1;     // next interval at the new speed
            end
            else
                cnt_m = cnt_m + 1;
            speed_m = spd;
            tick_m  = (cnt_m == last_m);

            if (mode != MODE_PLAY)
            begin
                dir_m    = DIR_RIGHT;
                moving_m = 1'b0;
            end
            else if (!dead_m && keys != 4'b0000)
            begin
                if (keys[0])
                    req = DIR_UP;
                else if (keys[1])
                    req = DIR_DOWN;
                else if (keys[2])
                    req = moving_m ? DIR_LEFT : DIR_RIGHT;
                else
                    req = DIR_RIGHT;
                if (!is_reverse(req, dir_m))
                    dir_m = req;
                moving_m = 1'b1;
            end

            if (mode == MODE_MENU)
            begin
                dead_m   = 1'b0;
                len_m    = init_len;
                food_x_m = int'(`SNAKE_FOOD_X0);
                food_y_m = int'(`SNAKE_FOOD_Y0);
                for (int i = 0; i < max_len; i++)
                begin
                    seg_x_m[i] = int'(`SNAKE_INIT_X) - blk * i;
                    seg_y_m[i] = int'(`SNAKE_INIT_Y);
                end
            end
            else if (step_m)
            begin
                dead_m = dead_m | wall | coll;
                if (eat)
                begin
                    eats_m = eats_m + 1;
                    if (len_m < max_len)
                        len_m = len_m + 1;
                    food_x_m = side_w + blk *
                        ((13 * nx + 7 * seg_x_m[0] + 2 * seg_x_m[1] + seed_x_m + 234) % 60);
                    food_y_m = side_w + blk *
                        ((13 * ny + 7 * seg_y_m[0] + 2 * seg_y_m[1] + seed_y_m + 123) % 32);
                end
                for (int i = max_len - 1; i > 0; i--)
                begin
                    seg_x_m[i] = seg_x_m[i-1];
                    seg_y_m[i] = seg_y_m[i-1];
                end
                seg_x_m[0] = nx;
                seg_y_m[0] = ny;
            end

            // seed generators: +1, then xor with the upper eight bits under a prefix
            seed_x_m = ((seed_x_m + 1) & 32'h7ff) ^ (32'h500 | (seed_x_m >> 3));
            seed_y_m = ((seed_y_m + 1) & 32'h7ff) ^ (32'h200 | (seed_y_m >> 3));
        end
    end

    always @(negedge pixel_clk)
    begin
        if (sys_rst_n)
        begin
            checks = checks + 1;
            if (pixel_data !== pix_m)
            begin
                errors = errors + 1;
                $display("Error: pixel_data = %h, expected %h at %0t", pixel_data, pix_m, $time);
            end
            if (score !== score_m)
            begin
                errors = errors + 1;
                $display("Error: score = %h, expected %h at %0t", score, score_m, $time);
            end
            if (dead !== dead_m)
            begin
                errors = errors + 1;
                $display("Error: dead = %h, expected %h at %0t", dead, dead_m, $time);
            end
            if (snake_video_top_i.step_tick !== tick_m)
            begin
                errors = errors + 1;
                $display("Error: step_tick = %h, expected %h at %0t",
                         snake_video_top_i.step_tick, tick_m, $time);
            end
            if (snake_video_top_i.food_pos !== {11'(food_x_m), 11'(food_y_m)})
            begin
                errors = errors + 1;
                $display("Error: food_pos = %h, expected %h at %0t", snake_video_top_i.food_pos,
                         {11'(food_x_m), 11'(food_y_m)}, $time);
            end
        end
    end

    // mostly head for the food, sometimes a random key (reversals too) or none
    task automatic choose_keys();
        int dx;
        int dy;
        int r;
        dx = food_x_m - seg_x_m[0];
        dy = food_y_m - seg_y_m[0];
        r  = rand_below(8);
        if (force_up)
            keys = 4'b0001;
        else if (r == 0)
            keys = 4'b0001 << rand_below(4);
        else if (r == 1)
            keys = 4'b0000;
        else if (dx > 0 && dir_m != DIR_LEFT)
            keys = 4'b1000;
        else if (dx < 0 && dir_m != DIR_RIGHT)
            keys = 4'b0100;
        else if (dy > 0 && dir_m != DIR_UP)
            keys = 4'b0010;
        else if (dy < 0 && dir_m != DIR_DOWN)
            keys = 4'b0001;
        else if (dir_m == DIR_UP || dir_m == DIR_DOWN)
            keys = (seg_x_m[0] < 640) ? 4'b1000 : 4'b0100;
        else
            keys = (seg_y_m[0] < 360) ? 4'b0010 : 4'b0001;
    endtask

    // sample head, body, food, border or anywhere
    task automatic pick_pixel();
        int sel;
        int k;
        int px;
        int py;
        sel = rand_below(6);
        k   = rand_below(len_m);
        px  = rand_below(h_disp);
        py  = rand_below(v_disp);
        case (sel)
            0:
            begin
                px = seg_x_m[0] + rand_below(blk);
                py = seg_y_m[0] + rand_below(blk);
            end
            1:
            begin
                px = seg_x_m[k] + rand_below(blk);
                py = seg_y_m[k] + rand_below(blk);
            end
            2:
            begin
                px = food_x_m + rand_below(blk);
                py = food_y_m + rand_below(blk);
            end
            3:
                if (rand_below(2) == 0)
                    py = rand_below(side_w);
                else
                    px = h_disp - 1 - rand_below(side_w);
            default: ;
        endcase
        pixel_pos.x = 11'(px);
        pixel_pos.y = 11'(py);
    endtask

    task automatic drive_cycle();
        @(posedge pixel_clk);
        #1;
        speed_step = (rand_below(48) == 0);
        if (step_m || !moving_m || mode == MODE_MENU || dead_m)  // one turn per step
            choose_keys();
        pick_pixel();
    endtask

    initial
    begin
        int n;
        seed       = 32'hfc3d_fe32;
        errors     = 0;
        checks     = 0;
        eats_m     = 0;
        force_up   = 1'b0;
        sys_rst_n  = 1'b0;
        mode       = MODE_MENU;
        keys       = 4'b0000;
        speed_step = 1'b0;
        pixel_pos  = '0;
        repeat (2) @(posedge pixel_clk);
        #1 sys_rst_n = 1'b1;

        for (n = 0; n < 100; n++)
            drive_cycle();
        if (score !== 7'd0 || dead !== 1'b0)
        begin
            errors = errors + 1;
            $display("menu after reset does not show a zero score and a live game");
        end

        for (int round = 0; round < 4; round++)
        begin
            mode     = MODE_PLAY;
            force_up = 1'b0;
            n = 0;
            while (dead !== 1'b1 && n < 40000)
            begin
                drive_cycle();
                n++;
            end
            force_up = 1'b1;                // steer into a wall
            n = 0;
            while (dead !== 1'b1 && n < 4000)
            begin
                drive_cycle();
                n++;
            end
            if (dead !== 1'b1)
            begin
                errors = errors + 1;
                $display("timeout: dead never rose in round %0d", round);
            end
            for (n = 0; n < 200; n++)
                drive_cycle();
            mode = MODE_MENU;
            for (n = 0; n < 100; n++)
                drive_cycle();
            if (dead !== 1'b0 || score !== 7'd0)
            begin
                errors = errors + 1;
                $display("menu did not clear dead and score in round %0d", round);
            end
        end

        if (eats_m == 0)
        begin
            errors = errors + 1;
            $display("the snake never reached the food");
        end
        errors = errors + snake_video_top_i.chk_i.fail_cnt;
        $display("checks: %0d  errors: %0d  food eaten: %0d", checks, errors, eats_m);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // all loops above are bounded, this only guards against a stuck clock
    initial
    begin
        #2_000_000;
        $display("timeout: simulation ran past its time limit");
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- sources.f
+incdir+hdl
hdl/snake_pkg.sv
hdl/snake_steer.sv
hdl/snake_step_timer.sv
hdl/snake_head.sv
hdl/snake_segment.sv
hdl/snake_pixel_mix.sv
hdl/snake_video_top.sv
dv/snake_checker.sv
dv/snake_tb.sv

//--- run.sh
#!/bin/sh
# build the snake testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module snake_tb \
    -f sources.f -o snake_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/snake_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
